//--- hw/flow_arb_rr.sv
/*
 * Flow-controlled round-robin arbiter
 * Turns requester valids and pop readiness into per-requester ready
 */

`timescale 1ns/1ps

module flow_arb_rr (
  input  logic                     clk,
  input  logic                     rst,
  input  flow_merge_pkg::req_vec_t push_valid,
  output flow_merge_pkg::req_vec_t push_ready,
  input  logic                     pop_ready,
  output logic                     pop_valid,
  output flow_merge_pkg::req_vec_t grant
);

  // Priority only moves when the pop side takes the item
  logic enable;

  // ----------------------------------------
  // Arbitration
  // ----------------------------------------

  assign enable = pop_ready;

  rr_arb i_rr_arb (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .request (push_valid),
    .grant   (grant)
  );

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Only the granted requester sees ready
  // and only while the pop side can accept
  assign push_ready = grant & {flow_merge_pkg::num_req{pop_ready}};

  // Any valid request yields a pop item, grant is never empty then
  assign pop_valid = |push_valid;

endmodule : flow_arb_rr

//--- hw/flow_merge.sv
/*
 * Four-way stream merge top level
 * Round-robin arbiter, tagged payload mux and registered output buffer
 */

`timescale 1ns/1ps

module flow_merge (
  input  logic                      clk,
  input  logic                      rst,
  input  flow_merge_pkg::req_vec_t  push_valid,
  output flow_merge_pkg::req_vec_t  push_ready,
  input  logic [flow_merge_pkg::num_req-1:0][flow_merge_pkg::data_w-1:0] push_data,
  output logic                      out_valid,
  input  logic                      out_ready,
  output flow_merge_pkg::pop_item_t out_item
);

  // ----------------------------------------
  // Internal wires
  // ----------------------------------------

  // One-hot winner of the current cycle
  flow_merge_pkg::req_vec_t grant;

  // Arbiter to buffer handshake
  logic pop_valid;
  logic pop_ready;

  // Tagged item from the mux
  flow_merge_pkg::pop_item_t in_item;

  // ----------------------------------------
  // Blocks
  // ----------------------------------------

  flow_arb_rr i_flow_arb_rr (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .grant      (grant)
  );

  grant_mux i_grant_mux (
    .grant     (grant),
    .push_data (push_data),
    .item      (in_item)
  );

  // Registered output, one cycle to out_valid when empty
  pop_skid i_pop_skid (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pop_valid),
    .in_ready  (pop_ready),
    .in_item   (in_item),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_item  (out_item)
  );

endmodule : flow_merge

//--- hw/flow_merge_pkg.sv
/*
 * Four-way stream merge shared definitions
 * Requester count, payload and index widths, and the merged output item
 */

package flow_merge_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------

  // Number of merged requester streams
  localparam int num_req = 4;

  // Payload width of one requester word
  localparam int data_w = 16;

  // Source index width, wide enough for every requester
  localparam int src_w = $clog2(num_req);

  // ----------------------------------------
  // Types
  // ----------------------------------------

  // One bit per requester
  // Used for request, grant and ready masks
  typedef logic [num_req-1:0] req_vec_t;

  // Merged output item
  // Source index in the upper bits, payload below
  typedef struct packed {
    logic [src_w-1:0]  src;
    logic [data_w-1:0] data;
  } pop_item_t;

endpackage : flow_merge_pkg

//--- hw/grant_mux.sv
/*
 * Grant-selected payload mux
 * Picks the granted word and tags it with its source index
 */

`timescale 1ns/1ps

module grant_mux (
  input  flow_merge_pkg::req_vec_t grant,
  input  logic [flow_merge_pkg::num_req-1:0][flow_merge_pkg::data_w-1:0] push_data,
  output flow_merge_pkg::pop_item_t item
);

  // Per-requester mask of the payload bits
  logic [flow_merge_pkg::data_w-1:0] data_sel;

  // Source index of the granted requester
  logic [flow_merge_pkg::src_w-1:0] src_sel;

  // ----------------------------------------
  // AND-OR select
  // ----------------------------------------

  // Grant is one-hot, so OR of masked words gives the granted word
  // Index encode rides in the same loop
  always_comb begin
    data_sel = '0;
    src_sel  = '0;
    for (int i = 0; i < flow_merge_pkg::num_req; i++) begin
      data_sel = data_sel | (push_data[i] & {flow_merge_pkg::data_w{grant[i]}});
      if (grant[i]) begin
        src_sel = src_sel | i[flow_merge_pkg::src_w-1:0];
      end
    end
  end

  // Zero grant gives zero item, no valid goes with it
  assign item.src  = src_sel;
  assign item.data = data_sel;

endmodule : grant_mux

//--- hw/pop_skid.sv
/*
 * Two-entry output skid buffer
 * Registers the merged stream and absorbs one item of back-pressure
 */

`timescale 1ns/1ps

module pop_skid (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  flow_merge_pkg::pop_item_t in_item,
  output logic                      out_valid,
  input  logic                      out_ready,
  output flow_merge_pkg::pop_item_t out_item
);

  // Occupancy, 0 to 2 entries
  logic [1:0] count_q;
  logic [1:0] count_d;

  // Main holds the oldest entry, skid the one behind it
  flow_merge_pkg::pop_item_t main_q;
  flow_merge_pkg::pop_item_t skid_q;

  // Transfers on each side
  logic push;
  logic pop;

  // ----------------------------------------
  // Handshake
  // ----------------------------------------

  // Both come straight from the count flop
  // so out_ready never reaches the requesters combinationally
  assign in_ready  = (count_q != 2'd2);
  assign out_valid = (count_q != 2'd0);
  assign out_item  = main_q;

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // ----------------------------------------
  // Occupancy
  // ----------------------------------------

  always_comb begin
    count_d = count_q;
    if (push && !pop) begin
      count_d = count_q + 2'd1;
    end else if (pop && !push) begin
      count_d = count_q - 2'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= 2'd0;
    end else begin
      count_q <= count_d;
    end
  end

  // ----------------------------------------
  // Storage
  // ----------------------------------------

  always_ff @(posedge clk) begin
    // Skid drains into main when the head leaves
    if (pop && count_q == 2'd2) begin
      main_q <= skid_q;
    end
    // Fill main when empty, or when the head leaves with one entry
    if (push && (count_q == 2'd0 || (count_q == 2'd1 && pop))) begin
      main_q <= in_item;
    end
    // Stall with one entry, new item parks in skid
    if (push && count_q == 2'd1 && !pop) begin
      skid_q <= in_item;
    end
  end

endmodule : pop_skid

//--- hw/rr_arb.sv
/*
 * Round-robin arbiter core
 * One-hot grant among valid requests, priority pointer advances on enable
 */

`timescale 1ns/1ps

module rr_arb (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     enable,
  input  flow_merge_pkg::req_vec_t request,
  output flow_merge_pkg::req_vec_t grant
);

  // One-hot priority pointer, set bit has highest priority
  flow_merge_pkg::req_vec_t prio_q;
  flow_merge_pkg::req_vec_t prio_d;

  // Pointer as a binary index
  logic [flow_merge_pkg::src_w-1:0] ptr_idx;

  // Request and grant in pointer-relative order
  flow_merge_pkg::req_vec_t rot_req;
  flow_merge_pkg::req_vec_t rot_grant;

  // Doubled vectors make the rotation a plain shift
  logic [2*flow_merge_pkg::num_req-1:0] req_dbl;
  logic [2*flow_merge_pkg::num_req-1:0] grant_dbl;

  // ----------------------------------------
  // Grant
  // ----------------------------------------

  // Encode the one-hot pointer
  always_comb begin
    ptr_idx = '0;
    for (int i = 0; i < flow_merge_pkg::num_req; i++) begin
      if (prio_q[i]) begin
        ptr_idx = ptr_idx | i[flow_merge_pkg::src_w-1:0];
      end
    end
  end

  // Rotate so the pointer position lands at bit 0
  assign req_dbl = {request, request} >> ptr_idx;
  assign rot_req = req_dbl[flow_merge_pkg::num_req-1:0];

  // First set bit wins
  assign rot_grant = rot_req & (~rot_req + 1'b1);

  // Rotate back to requester order
  assign grant_dbl = {rot_grant, rot_grant} << ptr_idx;
  assign grant = grant_dbl[2*flow_merge_pkg::num_req-1:flow_merge_pkg::num_req];

  // ----------------------------------------
  // Priority state
  // ----------------------------------------

  // Next priority goes to the requester after the granted one
  assign prio_d = {grant[flow_merge_pkg::num_req-2:0],
                   grant[flow_merge_pkg::num_req-1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      // Requester 0 first after reset
      prio_q <= {{(flow_merge_pkg::num_req-1){1'b0}}, 1'b1};
    end else if (enable && |request) begin
      prio_q <= prio_d;
    end
  end

endmodule : rr_arb

//--- run_sim.sh
#!/bin/sh
# Build and run the stream merge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert \
  --top-module flow_merge_tb -Mdir "$OBJ" -f sources.f
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit 1
fi

"./$OBJ/Vflow_merge_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
  echo "Simulation ended without a result line"
  exit 1
fi
exit 0

//--- sources.f
hw/flow_merge_pkg.sv
hw/rr_arb.sv
hw/flow_arb_rr.sv
hw/grant_mux.sv
hw/pop_skid.sv
hw/flow_merge.sv
test/flow_merge_chk.sv
test/flow_merge_tb.sv

//--- test/flow_merge_chk.sv
/*
 * Handshake and grant checks for the stream merge
 * Bound into the top level, reports through assertion failures
 */

`timescale 1ns/1ps

module flow_merge_chk (
  input logic                      clk,
  input logic                      rst,
  input flow_merge_pkg::req_vec_t  grant,
  input flow_merge_pkg::req_vec_t  push_ready,
  input logic                      out_valid,
  input logic                      out_ready,
  input flow_merge_pkg::pop_item_t out_item
);

  // ----------------------------------------
  // Arbiter
  // ----------------------------------------

  // At most one winner per cycle
  grant_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(grant))
    else $error("grant has more than one bit set");

  // Only the winner may see ready
  ready_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0(push_ready))
    else $error("push_ready has more than one bit set");

  // ----------------------------------------
  // Output stream
  // ----------------------------------------

  // Stalled item holds until taken
  out_stable: assert property (@(posedge clk) disable iff (rst)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_item)))
    else $error("out_item changed or out_valid dropped while stalled");

  // Buffer comes out of reset empty
  reset_idle: assert property (@(posedge clk)
    rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

endmodule : flow_merge_chk

bind flow_merge flow_merge_chk i_flow_merge_chk (
  .clk        (clk),
  .rst        (rst),
  .grant      (grant),
  .push_ready (push_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_item   (out_item)
);

//--- test/flow_merge_tb.sv
/*
 * Testbench for the four-way stream merge
 * Table-driven requester bursts, reference arbiter model and scoreboard
 */

`timescale 1ns/1ps

module flow_merge_tb;

  localparam int num_rows = 5;

  // DUT ports
  logic                     clk;
  logic                     rst;
  flow_merge_pkg::req_vec_t push_valid;
  flow_merge_pkg::req_vec_t push_ready;
  logic [flow_merge_pkg::num_req-1:0][flow_merge_pkg::data_w-1:0] push_data;
  logic                      out_valid;
  logic                      out_ready;
  flow_merge_pkg::pop_item_t out_item;

  // Stimulus table, one row per test
  string                    test_name  [num_rows];
  flow_merge_pkg::req_vec_t test_mask  [num_rows];
  int                       burst_len  [num_rows][flow_merge_pkg::num_req];
  bit                       rand_ready [num_rows];

  // Driver state, words sent per requester
  int                       sent [flow_merge_pkg::num_req];
  flow_merge_pkg::req_vec_t last_xfer;

  // Reference model, pointer index and buffer occupancy
  int                        model_ptr;
  int                        model_cnt;
  flow_merge_pkg::pop_item_t exp_q [$];

  int seed;
  int err_cnt;
  int item_cnt;
  int cycle_cnt = 0;
  int cycle_limit;

  flow_merge i_flow_merge (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_item   (out_item)
  );

  always #5 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Testbench failed");
      $finish;
    end
  end

  // ----------------------------------------
  // Table and helpers
  // ----------------------------------------

  task automatic set_row(input int r, input string name, input flow_merge_pkg::req_vec_t mask,
                         input int b0, input int b1, input int b2, input int b3, input bit rnd);
    test_name[r]    = name;
    test_mask[r]    = mask;
    burst_len[r][0] = b0;
    burst_len[r][1] = b1;
    burst_len[r][2] = b2;
    burst_len[r][3] = b3;
    rand_ready[r]   = rnd;
  endtask

  task automatic load_table();
    //      row  name            mask     bursts             random ready
    set_row(0, "single_pass",   4'b0100, 0, 0, 8, 0, 1'b0);
    set_row(1, "reset_rotate",  4'b1111, 6, 6, 6, 6, 1'b0);
    set_row(2, "sparse_mask",   4'b1010, 0, 5, 0, 5, 1'b0);
    set_row(3, "back_pressure", 4'b1111, 8, 8, 8, 8, 1'b1);
    set_row(4, "unequal_burst", 4'b1111, 2, 6, 3, 8, 1'b0);
  endtask

  // Requester index in the top nibble, running count below
  function automatic logic [flow_merge_pkg::data_w-1:0] word_of(input int idx, input int cnt);
    word_of = {idx[3:0], cnt[11:0]};
  endfunction

  // First valid requester at or after the pointer, -1 when none
  function automatic int pick_next(input int ptr, input flow_merge_pkg::req_vec_t valid);
    int idx;
    pick_next = -1;
    for (int k = flow_merge_pkg::num_req - 1; k >= 0; k--) begin
      idx = (ptr + k) % flow_merge_pkg::num_req;
      if (valid[idx]) begin
        pick_next = idx;
      end
    end
  endfunction

  task automatic drive_inputs(input int r);
    int rnd;
    for (int i = 0; i < flow_merge_pkg::num_req; i++) begin
      push_valid[i] = test_mask[r][i] && (sent[i] < burst_len[r][i]);
      push_data[i]  = word_of(i, sent[i]);
    end
    rnd = $random(seed);
    out_ready = rand_ready[r] ? rnd[0] : 1'b1;
  endtask

  // ----------------------------------------
  // Model and scoreboard, at the falling edge
  // ----------------------------------------

  task automatic check_cycle();
    flow_merge_pkg::pop_item_t exp_item;
    flow_merge_pkg::req_vec_t  exp_ready;
    int                        g;
    bit                        model_pop;
    // Output side
    assert (out_valid == (model_cnt != 0)) else begin
      $display("Error at %0t: out_valid expected %b, got %b", $time, model_cnt != 0, out_valid);
      err_cnt++;
    end
    if (out_valid && out_ready) begin
      assert (exp_q.size() > 0) else begin
        $display("Output item at %0t arrived with no item pending in the model", $time);
        err_cnt++;
      end
      if (exp_q.size() > 0) begin
        exp_item = exp_q.pop_front();
        assert (out_item.src == exp_item.src) else begin
          $display("Error at %0t: out_item.src expected %0d, got %0d",
                   $time, exp_item.src, out_item.src);
          err_cnt++;
        end
        assert (out_item.data == exp_item.data) else begin
          $display("Error at %0t: out_item.data expected %h, got %h",
                   $time, exp_item.data, out_item.data);
          err_cnt++;
        end
        item_cnt++;
      end
    end
    // Arbitration, room in the buffer means the pop side is ready
    exp_ready = '0;
    g = pick_next(model_ptr, push_valid);
    if (model_cnt != 2 && g >= 0) begin
      exp_ready[g] = 1'b1;
    end
    assert (push_ready == exp_ready) else begin
      $display("Error at %0t: push_ready expected %b, got %b", $time, exp_ready, push_ready);
      err_cnt++;
    end
    if (exp_ready != '0) begin
      exp_item.src  = g[flow_merge_pkg::src_w-1:0];
      exp_item.data = word_of(g, sent[g]);
      exp_q.push_back(exp_item);
      model_ptr = (g + 1) % flow_merge_pkg::num_req;
    end
    model_pop = (model_cnt != 0) && out_ready;
    model_cnt = model_cnt + ((exp_ready != '0) ? 1 : 0) - (model_pop ? 1 : 0);
    last_xfer = push_valid & push_ready;
  endtask

  // ----------------------------------------
  // One table row
  // ----------------------------------------

  task automatic run_row(input int r);
    int err_start;
    int item_start;
    int exp_total;
    bit done;
    err_start  = err_cnt;
    item_start = item_cnt;
    exp_total  = 0;
    for (int i = 0; i < flow_merge_pkg::num_req; i++) begin
      exp_total += test_mask[r][i] ? burst_len[r][i] : 0;
      sent[i] = 0;
    end
    // Each test starts from reset, requester 0 first
    rst        = 1'b1;
    push_valid = '0;
    out_ready  = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst       = 1'b0;
    model_ptr = 0;
    model_cnt = 0;
    exp_q.delete();
    drive_inputs(r);
    done = 1'b0;
    while (!done) begin
      @(negedge clk);
      check_cycle();
      @(posedge clk);
      #1;
      for (int i = 0; i < flow_merge_pkg::num_req; i++) begin
        if (last_xfer[i]) begin
          sent[i]++;
        end
      end
      drive_inputs(r);
      done = (push_valid == '0) && (exp_q.size() == 0);
    end
    assert (item_cnt - item_start == exp_total) else begin
      $display("Error at %0t: item count expected %0d, got %0d",
               $time, exp_total, item_cnt - item_start);
      err_cnt++;
    end
    $display("Test %s: %0d of %0d items, %0d errors",
             test_name[r], item_cnt - item_start, exp_total, err_cnt - err_start);
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    push_valid = '0;
    push_data  = '0;
    out_ready  = 1'b0;
    last_xfer  = '0;
    seed       = 36;
    err_cnt    = 0;
    item_cnt   = 0;
    load_table();
    cycle_limit = 0;
    for (int r = 0; r < num_rows; r++) begin
      for (int i = 0; i < flow_merge_pkg::num_req; i++) begin
        cycle_limit += burst_len[r][i];
      end
    end
    cycle_limit = 4 * cycle_limit + 100;
    for (int r = 0; r < num_rows; r++) begin
      run_row(r);
    end
    $display("Summary: %0d tests, %0d items checked, %0d errors", num_rows, item_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : flow_merge_tb
